// ==== flist.f ====
common/pcie_ts_pkg.sv
verilog/rx_lane_align.sv
ts_parser/ts_parser.sv
link_ts_monitor/link_ts_monitor.sv
verilog/pcie_ts_rx_top.sv
bench/tb_clk_gen.sv
bench/pcie_ts_rx_tb.sv

// ==== Makefile ====
# Verilator build, run and lint for the PCIe training set receiver

VERILATOR ?= verilator
TOP       ?= pcie_ts_rx_tb
RTL_TOP   ?= pcie_ts_rx_top
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing -Wall
PASS_MSG  ?= ** PASS **

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

# The run passes only when the pass message shows up in the output
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF -- '$(PASS_MSG)'

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR)

// ==== bench/pcie_ts_rx_tb.sv ====
`timescale 1ns/1ps

module pcie_ts_rx_tb;

	localparam int nl = pcie_ts_pkg::num_lanes;
	localparam int lock = pcie_ts_pkg::ts_lock_count;
	// Last input word to monitor output, DUT latency
	localparam int settle_cycles = 4;
	// Sets sent over the whole run, 20 cycles allowed per set word
	localparam int total_sets = 58;
	localparam int watchdog_cycles = total_sets * pcie_ts_pkg::ts_words * 20 + 10;
	// Longest burst of sets, plus one idle byte either side
	localparam int max_bytes = 8 * 16 + 2;
	// Lane numbering schemes
	localparam int order_pad = 0;
	localparam int order_normal = 1;
	localparam int order_reversed = 2;

	logic                              clk;
	logic                              rst_n;
	logic [nl*16-1:0]                  rx_data;
	logic [nl*2-1:0]                   rx_charisk;
	logic [nl*2-1:0]                   rx_err;
	logic                              ts1_locked;
	logic                              ts2_locked;
	logic                              link_num_valid;
	logic [pcie_ts_pkg::link_w-1:0]    link_num;
	logic                              lanes_normal;
	logic                              lanes_reversed;
	logic                              speed_5g;
	logic [pcie_ts_pkg::fts_w-1:0]     num_fts_max;

	// Set contents per lane, -1 stands for PAD
	logic cfg_ts2;
	int   cfg_link [nl];
	int   cfg_lane [nl];
	int   cfg_fts  [nl];
	logic cfg_rate [nl];
	logic cfg_skew [nl];

	// Expected run of identical sets per lane
	int   run_len  [nl];
	logic run_ts2  [nl];
	int   run_link [nl];
	int   run_lane [nl];
	logic run_rate [nl];

	// Byte stream per lane, {err, k, symbol}
	logic [9:0] stream [nl][max_bytes];

	int    errors;
	int    prop_errors;
	int    checks;
	int    tests_run;
	int    tests_failed;
	int    test_errs;
	string test_name;
	int    seed;

	tb_clk_gen u_clk (
		.clk   (clk),
		.rst_n (rst_n)
	);

	pcie_ts_rx_top uut (
		.clk            (clk),
		.rst_n          (rst_n),
		.rx_data        (rx_data),
		.rx_charisk     (rx_charisk),
		.rx_err         (rx_err),
		.ts1_locked     (ts1_locked),
		.ts2_locked     (ts2_locked),
		.link_num_valid (link_num_valid),
		.link_num       (link_num),
		.lanes_normal   (lanes_normal),
		.lanes_reversed (lanes_reversed),
		.speed_5g       (speed_5g),
		.num_fts_max    (num_fts_max)
	);

	// Every level output leaves reset low
	assert property (@(posedge clk) $rose(rst_n) |->
		!ts1_locked && !ts2_locked && !link_num_valid && !lanes_normal &&
		!lanes_reversed && !speed_5g && (num_fts_max == '0))
	else begin
		$display("[FAIL] %0t ns: outputs not at their reset values after reset", $time);
		prop_errors++;
	end

	// Symbol b of a training set on lane ln, {k, symbol}
	function automatic logic [8:0] ts_symbol(int ln, int b);
		logic [7:0] id;
		id = cfg_ts2 ? pcie_ts_pkg::ts2_id : pcie_ts_pkg::ts1_id;
		case (b)
			0: return {1'b1, pcie_ts_pkg::sym_com};
			1: return (cfg_link[ln] < 0) ? {1'b1, pcie_ts_pkg::sym_pad} : {1'b0, 8'(cfg_link[ln])};
			2: return (cfg_lane[ln] < 0) ? {1'b1, pcie_ts_pkg::sym_pad} : {1'b0, 8'(cfg_lane[ln])};
			3: return {1'b0, 8'(cfg_fts[ln])};
			// Rate ID, 2.5 GT/s always, bit 2 for 5 GT/s
			4: return {1'b0, 5'b0, cfg_rate[ln], 2'b10};
			5: return 9'h000;
			default: return {1'b0, id};
		endcase
	endfunction

	task automatic configure_lanes(logic ts2, int link, int order, logic rate);
		cfg_ts2 = ts2;
		for (int ln = 0; ln < nl; ln++) begin
			cfg_link[ln] = link;
			cfg_rate[ln] = rate;
			cfg_fts[ln]  = 32 + ln;
			cfg_skew[ln] = 1'b0;
			if (order == order_normal)
				cfg_lane[ln] = ln;
			else if (order == order_reversed)
				cfg_lane[ln] = nl - 1 - ln;
			else
				cfg_lane[ln] = -1;
		end
	endtask

	// A set equal to the last one extends the run, anything else restarts it
	task automatic count_set(int ln);
		logic same;
		same = (run_ts2[ln] == cfg_ts2) && (run_link[ln] == cfg_link[ln]) &&
			(run_lane[ln] == cfg_lane[ln]) && (run_rate[ln] == cfg_rate[ln]);
		if (!same)
			run_len[ln] = 1;
		else if (run_len[ln] < lock)
			run_len[ln]++;
		run_ts2[ln]  = cfg_ts2;
		run_link[ln] = cfg_link[ln];
		run_lane[ln] = cfg_lane[ln];
		run_rate[ln] = cfg_rate[ln];
	endtask

	// Sends n sets on every lane, err_lane gets a decode error in set err_set
	task automatic send_sets(int n, int err_lane, int err_set);
		int               pos;
		int               nbytes;
		logic [nl*16-1:0] word_data;
		logic [nl*2-1:0]  word_k;
		logic [nl*2-1:0]  word_err;
		nbytes = n * 16 + 2;
		for (int ln = 0; ln < nl; ln++) begin
			pos = 0;
			// Skewed lane starts one byte late, comma in the high byte
			if (cfg_skew[ln]) begin
				stream[ln][pos] = '0;
				pos++;
			end
			for (int s = 0; s < n; s++) begin
				for (int b = 0; b < 16; b++) begin
					stream[ln][pos] = {(ln == err_lane && s == err_set && b == 4),
						ts_symbol(ln, b)};
					pos++;
				end
				// An errored set is dropped by the parser
				if (!(ln == err_lane && s == err_set))
					count_set(ln);
			end
			while (pos < nbytes) begin
				stream[ln][pos] = '0;
				pos++;
			end
		end
		for (int w = 0; w < nbytes / 2; w++) begin
			for (int ln = 0; ln < nl; ln++) begin
				word_data[16*ln +: 16] = {stream[ln][2*w+1][7:0], stream[ln][2*w][7:0]};
				word_k[2*ln +: 2]      = {stream[ln][2*w+1][8], stream[ln][2*w][8]};
				word_err[2*ln +: 2]    = {stream[ln][2*w+1][9], stream[ln][2*w][9]};
			end
			@(posedge clk);
			rx_data    <= word_data;
			rx_charisk <= word_k;
			rx_err     <= word_err;
		end
		repeat (settle_cycles) @(posedge clk);
		@(negedge clk);
	endtask

	task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
		checks++;
		assert (got === exp)
		else begin
			$display("[FAIL] %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
			errors++;
		end
	endtask

	// Link-wide results expected from the lane runs and the sent fields
	task automatic check_outputs();
		logic exp_ts1;
		logic exp_ts2;
		logic exp_link;
		logic exp_normal;
		logic exp_reversed;
		logic exp_speed;
		int   exp_fts;
		exp_ts1      = 1'b1;
		exp_ts2      = 1'b1;
		exp_link     = 1'b1;
		exp_normal   = 1'b1;
		exp_reversed = 1'b1;
		exp_speed    = 1'b1;
		exp_fts      = 0;
		for (int ln = 0; ln < nl; ln++) begin
			if (run_len[ln] < lock || run_ts2[ln])
				exp_ts1 = 1'b0;
			if (run_len[ln] < lock || !run_ts2[ln])
				exp_ts2 = 1'b0;
			if (cfg_link[ln] < 0 || cfg_link[ln] != cfg_link[0])
				exp_link = 1'b0;
			if (cfg_lane[ln] != ln)
				exp_normal = 1'b0;
			if (cfg_lane[ln] != nl - 1 - ln)
				exp_reversed = 1'b0;
			if (!cfg_rate[ln])
				exp_speed = 1'b0;
			if (cfg_fts[ln] > exp_fts)
				exp_fts = cfg_fts[ln];
		end
		check_value("ts1_locked", 32'(ts1_locked), 32'(exp_ts1));
		check_value("ts2_locked", 32'(ts2_locked), 32'(exp_ts2));
		check_value("link_num_valid", 32'(link_num_valid), 32'(exp_link));
		if (exp_link)
			check_value("link_num", 32'(link_num), cfg_link[0]);
		check_value("lanes_normal", 32'(lanes_normal), 32'(exp_normal));
		check_value("lanes_reversed", 32'(lanes_reversed), 32'(exp_reversed));
		check_value("speed_5g", 32'(speed_5g), 32'(exp_speed));
		check_value("num_fts_max", 32'(num_fts_max), exp_fts);
	endtask

	task automatic begin_test(string name);
		test_name = name;
		test_errs = errors;
		tests_run++;
	endtask

	task automatic end_test();
		if (errors == test_errs) begin
			$display("test %0d %s: ok", tests_run, test_name);
		end else begin
			$display("test %0d %s: %0d errors", tests_run, test_name, errors - test_errs);
			tests_failed++;
		end
	endtask

	initial begin
		seed         = 32'h540be678;
		rx_data      = '0;
		rx_charisk   = '0;
		rx_err       = '0;
		errors       = 0;
		prop_errors  = 0;
		checks       = 0;
		tests_run    = 0;
		tests_failed = 0;
		// Lane runs start empty, fields as the monitor resets them
		for (int ln = 0; ln < nl; ln++) begin
			run_len[ln]  = 0;
			run_ts2[ln]  = 1'b0;
			run_link[ln] = -1;
			run_lane[ln] = -1;
			run_rate[ln] = 1'b0;
		end
		wait (rst_n === 1'b1);
		@(negedge clk);

		begin_test("PAD link and lane");
		check_value("ts1_locked after reset", 32'(ts1_locked), 0);
		check_value("num_fts_max after reset", 32'(num_fts_max), 0);
		configure_lanes(1'b0, -1, order_pad, 1'b0);
		// Seven sets are one short of lock
		send_sets(7, -1, 0);
		check_outputs();
		send_sets(1, -1, 0);
		check_outputs();
		end_test();

		begin_test("numbered TS2");
		configure_lanes(1'b1, 5, order_normal, 1'b1);
		send_sets(8, -1, 0);
		check_outputs();
		cfg_rate[2] = 1'b0;
		send_sets(1, -1, 0);
		check_outputs();
		end_test();

		begin_test("reversed lanes");
		configure_lanes(1'b0, 5, order_reversed, 1'b1);
		send_sets(8, -1, 0);
		check_outputs();
		for (int ln = 0; ln < nl; ln++)
			cfg_link[ln] = 5 + ln;
		send_sets(1, -1, 0);
		check_outputs();
		end_test();

		begin_test("error injection");
		configure_lanes(1'b0, 7, order_normal, 1'b0);
		// Decode error in the fifth set on lane 1
		send_sets(8, 1, 4);
		check_outputs();
		send_sets(8, -1, 0);
		check_outputs();
		end_test();

		begin_test("byte skew");
		configure_lanes(1'b0, 3, order_normal, 1'b1);
		cfg_skew[1] = 1'b1;
		cfg_skew[3] = 1'b1;
		send_sets(8, -1, 0);
		check_outputs();
		end_test();

		begin_test("random N_FTS");
		for (int ln = 0; ln < nl; ln++) begin
			cfg_skew[ln] = 1'b0;
			cfg_fts[ln]  = $random(seed) & 32'hff;
		end
		send_sets(8, -1, 0);
		check_outputs();
		end_test();

		errors = errors + prop_errors;
		$display("tests %0d, failed %0d, checks %0d, errors %0d",
			tests_run, tests_failed, checks, errors);
		if (errors == 0 && tests_failed == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

	// Stops a run that stalls
	initial begin
		repeat (watchdog_cycles) @(posedge clk);
		$display("Watchdog expired after %0d cycles, the tests did not finish",
			watchdog_cycles);
		$display("** FAIL **");
		$finish;
	end

endmodule

// ==== bench/tb_clk_gen.sv ====
`timescale 1ns/1ps

module tb_clk_gen (
	output logic clk,
	output logic rst_n
);

	// 100 ns clock period
	localparam int half_period = 50;
	localparam int reset_cycles = 10;

	initial begin
		clk = 1'b0;
		forever #half_period clk = ~clk;
	end

	// Reset low for the first cycles, released on a rising edge
	initial begin
		rst_n = 1'b0;
		repeat (reset_cycles) @(posedge clk);
		rst_n <= 1'b1;
	end

endmodule

// ==== verilog/pcie_ts_rx_top.sv ====
`timescale 1ns/1ps

module pcie_ts_rx_top (
	input  logic                                 clk,
	input  logic                                 rst_n,
	input  logic [pcie_ts_pkg::num_lanes*16-1:0] rx_data,
	input  logic [pcie_ts_pkg::num_lanes*2-1:0]  rx_charisk,
	input  logic [pcie_ts_pkg::num_lanes*2-1:0]  rx_err,
	output logic                                 ts1_locked,
	output logic                                 ts2_locked,
	output logic                                 link_num_valid,
	output logic [pcie_ts_pkg::link_w-1:0]       link_num,
	output logic                                 lanes_normal,
	output logic                                 lanes_reversed,
	output logic                                 speed_5g,
	output logic [pcie_ts_pkg::fts_w-1:0]        num_fts_max
);

	localparam int lw = pcie_ts_pkg::link_w;
	localparam int fw = pcie_ts_pkg::fts_w;

	// Comma-aligned symbol pairs
	logic [pcie_ts_pkg::num_lanes*16-1:0] al_data;
	logic [pcie_ts_pkg::num_lanes*2-1:0]  al_charisk;
	logic [pcie_ts_pkg::num_lanes*2-1:0]  al_err;

	// Parsed training set fields, one slice per lane
	logic [pcie_ts_pkg::num_lanes-1:0]    ts1_valid;
	logic [pcie_ts_pkg::num_lanes-1:0]    ts2_valid;
	logic [pcie_ts_pkg::num_lanes-1:0]    link_valid;
	logic [pcie_ts_pkg::num_lanes*lw-1:0] link;
	logic [pcie_ts_pkg::num_lanes-1:0]    lane_valid;
	logic [pcie_ts_pkg::num_lanes*lw-1:0] lane;
	logic [pcie_ts_pkg::num_lanes*fw-1:0] num_fts;
	logic [pcie_ts_pkg::num_lanes-1:0]    rate_5g;

	rx_lane_align u_align (
		.clk        (clk),
		.rst_n      (rst_n),
		.rx_data    (rx_data),
		.rx_charisk (rx_charisk),
		.rx_err     (rx_err),
		.al_data    (al_data),
		.al_charisk (al_charisk),
		.al_err     (al_err)
	);

	// One parser per lane
	for (genvar i = 0; i < pcie_ts_pkg::num_lanes; i++) begin : g_lane
		ts_parser u_parser (
			.clk        (clk),
			.rst_n      (rst_n),
			.rx_data    (al_data[16*i +: 16]),
			.rx_charisk (al_charisk[2*i +: 2]),
			.rx_err     (al_err[2*i +: 2]),
			.ts1_valid  (ts1_valid[i]),
			.ts2_valid  (ts2_valid[i]),
			.link_valid (link_valid[i]),
			.link       (link[i*lw +: lw]),
			.lane_valid (lane_valid[i]),
			.lane       (lane[i*lw +: lw]),
			.num_fts    (num_fts[i*fw +: fw]),
			.rate_5g    (rate_5g[i])
		);
	end

	link_ts_monitor u_monitor (
		.clk            (clk),
		.rst_n          (rst_n),
		.ts1_valid      (ts1_valid),
		.ts2_valid      (ts2_valid),
		.link_valid     (link_valid),
		.link           (link),
		.lane_valid     (lane_valid),
		.lane           (lane),
		.num_fts        (num_fts),
		.rate_5g        (rate_5g),
		.ts1_locked     (ts1_locked),
		.ts2_locked     (ts2_locked),
		.link_num_valid (link_num_valid),
		.link_num       (link_num),
		.lanes_normal   (lanes_normal),
		.lanes_reversed (lanes_reversed),
		.speed_5g       (speed_5g),
		.num_fts_max    (num_fts_max)
	);

endmodule

// ==== link_ts_monitor/link_ts_monitor.sv ====
`timescale 1ns/1ps

module link_ts_monitor (
	input  logic                                                clk,
	input  logic                                                rst_n,
	input  logic [pcie_ts_pkg::num_lanes-1:0]                   ts1_valid,
	input  logic [pcie_ts_pkg::num_lanes-1:0]                   ts2_valid,
	input  logic [pcie_ts_pkg::num_lanes-1:0]                   link_valid,
	input  logic [pcie_ts_pkg::num_lanes*pcie_ts_pkg::link_w-1:0] link,
	input  logic [pcie_ts_pkg::num_lanes-1:0]                   lane_valid,
	input  logic [pcie_ts_pkg::num_lanes*pcie_ts_pkg::link_w-1:0] lane,
	input  logic [pcie_ts_pkg::num_lanes*pcie_ts_pkg::fts_w-1:0]  num_fts,
	input  logic [pcie_ts_pkg::num_lanes-1:0]                   rate_5g,
	output logic                                                ts1_locked,
	output logic                                                ts2_locked,
	output logic                                                link_num_valid,
	output logic [pcie_ts_pkg::link_w-1:0]                      link_num,
	output logic                                                lanes_normal,
	output logic                                                lanes_reversed,
	output logic                                                speed_5g,
	output logic [pcie_ts_pkg::fts_w-1:0]                       num_fts_max
);

	localparam int lw = pcie_ts_pkg::link_w;
	localparam int fw = pcie_ts_pkg::fts_w;

	// Per lane run length and the set it was counted against
	logic [pcie_ts_pkg::lock_cnt_w-1:0]            run_cnt [pcie_ts_pkg::num_lanes];
	logic [pcie_ts_pkg::num_lanes-1:0]             last_ts2;
	logic [pcie_ts_pkg::num_lanes-1:0]             last_link_valid;
	logic [pcie_ts_pkg::num_lanes-1:0]             last_lane_valid;
	logic [pcie_ts_pkg::num_lanes-1:0]             last_rate;
	logic [pcie_ts_pkg::num_lanes*lw-1:0]          last_link;
	logic [pcie_ts_pkg::num_lanes*lw-1:0]          last_lane;

	logic [pcie_ts_pkg::num_lanes-1:0] same_set;
	logic [pcie_ts_pkg::num_lanes-1:0] lane_lock;
	logic                              any_strobe;

	// Link-wide results before registering
	logic          link_agree;
	logic          normal_c;
	logic          reversed_c;
	logic [fw-1:0] fts_max_c;

	always_comb begin
		for (int i = 0; i < pcie_ts_pkg::num_lanes; i++) begin
			// Same type and same fields as the previous set on this lane
			same_set[i] = (ts2_valid[i] == last_ts2[i]) &&
				(link_valid[i] == last_link_valid[i]) &&
				(link[i*lw +: lw] == last_link[i*lw +: lw]) &&
				(lane_valid[i] == last_lane_valid[i]) &&
				(lane[i*lw +: lw] == last_lane[i*lw +: lw]) &&
				(rate_5g[i] == last_rate[i]);
			lane_lock[i] = (int'(run_cnt[i]) >= pcie_ts_pkg::ts_lock_count);
		end
		any_strobe = |{ts1_valid, ts2_valid};
	end

	// Run counters, saturate at the lock threshold
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < pcie_ts_pkg::num_lanes; i++)
				run_cnt[i] <= '0;
			last_ts2        <= '0;
			last_link_valid <= '0;
			last_lane_valid <= '0;
			last_rate       <= '0;
			last_link       <= '0;
			last_lane       <= '0;
		end else begin
			for (int i = 0; i < pcie_ts_pkg::num_lanes; i++) begin
				if (ts1_valid[i] || ts2_valid[i]) begin
					// A changed set starts a new run of one
					if (!same_set[i])
						run_cnt[i] <= 1;
					else if (!lane_lock[i])
						run_cnt[i] <= run_cnt[i] + 1'b1;
					last_ts2[i]             <= ts2_valid[i];
					last_link_valid[i]      <= link_valid[i];
					last_lane_valid[i]      <= lane_valid[i];
					last_rate[i]            <= rate_5g[i];
					last_link[i*lw +: lw]   <= link[i*lw +: lw];
					last_lane[i*lw +: lw]   <= lane[i*lw +: lw];
				end
			end
		end
	end

	// Lock is per type, every lane must be in a full run of it
	assign ts1_locked = &(lane_lock & ~last_ts2);
	assign ts2_locked = &(lane_lock & last_ts2);

	always_comb begin
		link_agree = &link_valid;
		normal_c   = &lane_valid;
		reversed_c = &lane_valid;
		fts_max_c  = '0;
		for (int i = 0; i < pcie_ts_pkg::num_lanes; i++) begin
			// All lanes must carry lane 0's link number
			if (link[i*lw +: lw] != link[0 +: lw])
				link_agree = 1'b0;
			if (int'(lane[i*lw +: lw]) != i)
				normal_c = 1'b0;
			if (int'(lane[i*lw +: lw]) != pcie_ts_pkg::num_lanes - 1 - i)
				reversed_c = 1'b0;
			if (num_fts[i*fw +: fw] > fts_max_c)
				fts_max_c = num_fts[i*fw +: fw];
		end
	end

	// Link-wide outputs refresh on any lane's strobe
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			link_num_valid <= 1'b0;
			link_num       <= '0;
			lanes_normal   <= 1'b0;
			lanes_reversed <= 1'b0;
			speed_5g       <= 1'b0;
			num_fts_max    <= '0;
		end else if (any_strobe) begin
			link_num_valid <= link_agree;
			link_num       <= link_agree ? link[0 +: lw] : '0;
			lanes_normal   <= normal_c;
			lanes_reversed <= reversed_c;
			speed_5g       <= &rate_5g;
			num_fts_max    <= fts_max_c;
		end
	end

endmodule

// ==== ts_parser/ts_parser.sv ====
`timescale 1ns/1ps

module ts_parser (
	input  logic                           clk,
	input  logic                           rst_n,
	input  logic [15:0]                    rx_data,
	input  logic [1:0]                     rx_charisk,
	input  logic [1:0]                     rx_err,
	output logic                           ts1_valid,
	output logic                           ts2_valid,
	output logic                           link_valid,
	output logic [pcie_ts_pkg::link_w-1:0] link,
	output logic                           lane_valid,
	output logic [pcie_ts_pkg::link_w-1:0] lane,
	output logic [pcie_ts_pkg::fts_w-1:0]  num_fts,
	output logic                           rate_5g
);

	// Position within the training set
	typedef enum logic [2:0] {
		st_head,
		st_lane_fts,
		st_rate_ctl,
		st_id_first,
		st_ts1_id,
		st_ts2_id
	} state_t;

	state_t state;

	// Identifier pairs seen after the first one
	logic [$clog2(pcie_ts_pkg::ts_words)-1:0] id_cnt;

	// Decoded views of the current symbol pair
	logic       word_err;
	logic       lo_is_com;
	logic       hi_is_pad;
	logic       hi_is_num;
	logic       lo_is_pad;
	logic       lo_is_num;
	logic [7:0] id_sym;
	logic       id_word_ok;
	logic       id_last;

	always_comb begin
		word_err  = |rx_err;
		lo_is_com = rx_charisk[0] && (rx_data[7:0] == pcie_ts_pkg::sym_com);
		// Link number sits in the high byte of the comma pair
		hi_is_pad = rx_charisk[1] && (rx_data[15:8] == pcie_ts_pkg::sym_pad);
		hi_is_num = !rx_charisk[1] && (rx_data[15:8] <= 8'(pcie_ts_pkg::max_link_lane));
		// Lane number sits in the low byte of the next pair
		lo_is_pad = rx_charisk[0] && (rx_data[7:0] == pcie_ts_pkg::sym_pad);
		lo_is_num = !rx_charisk[0] && (rx_data[7:0] <= 8'(pcie_ts_pkg::max_link_lane));
		// Expected identifier depends on which set type was picked
		id_sym     = (state == st_ts2_id) ? pcie_ts_pkg::ts2_id : pcie_ts_pkg::ts1_id;
		id_word_ok = (rx_charisk == 2'b00) && (rx_data == {id_sym, id_sym});
		id_last    = (int'(id_cnt) == pcie_ts_pkg::ts_id_words - 1);
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state      <= st_head;
			id_cnt     <= '0;
			ts1_valid  <= 1'b0;
			ts2_valid  <= 1'b0;
			link_valid <= 1'b0;
			link       <= '0;
			lane_valid <= 1'b0;
			lane       <= '0;
			num_fts    <= '0;
			rate_5g    <= 1'b0;
		end else begin
			// Strobes are single cycle
			ts1_valid <= 1'b0;
			ts2_valid <= 1'b0;

			// Decode error anywhere in the pair kills the set
			if (word_err) begin
				state <= st_head;
			end else begin
				case (state)
					// Wait for comma plus PAD or link number
					st_head: begin
						if (lo_is_com && hi_is_pad) begin
							link_valid <= 1'b0;
							link       <= '0;
							state      <= st_lane_fts;
						end else if (lo_is_com && hi_is_num) begin
							link_valid <= 1'b1;
							link       <= rx_data[8 +: pcie_ts_pkg::link_w];
							state      <= st_lane_fts;
						end
					end

					// Lane number low, N_FTS high
					st_lane_fts: begin
						if (rx_charisk[1]) begin
							state <= st_head;
						end else if (lo_is_pad) begin
							lane_valid <= 1'b0;
							lane       <= '0;
							num_fts    <= rx_data[15:8];
							state      <= st_rate_ctl;
						end else if (lo_is_num) begin
							lane_valid <= 1'b1;
							lane       <= rx_data[0 +: pcie_ts_pkg::link_w];
							num_fts    <= rx_data[15:8];
							state      <= st_rate_ctl;
						end else begin
							state <= st_head;
						end
					end

					// Rate ID low, training control high, both data
					st_rate_ctl: begin
						if (|rx_charisk) begin
							state <= st_head;
						end else begin
							// Bit 2 advertises 5 GT/s
							rate_5g <= rx_data[2];
							state   <= st_id_first;
						end
					end

					// First identifier pair picks TS1 or TS2
					st_id_first: begin
						id_cnt <= '0;
						if (rx_charisk != 2'b00)
							state <= st_head;
						else if (rx_data == {pcie_ts_pkg::ts1_id, pcie_ts_pkg::ts1_id})
							state <= st_ts1_id;
						else if (rx_data == {pcie_ts_pkg::ts2_id, pcie_ts_pkg::ts2_id})
							state <= st_ts2_id;
						else
							state <= st_head;
					end

					// Remaining identifier pairs must all match
					st_ts1_id, st_ts2_id: begin
						if (id_word_ok) begin
							id_cnt <= id_cnt + 1'b1;
							if (id_last) begin
								ts1_valid <= (state == st_ts1_id);
								ts2_valid <= (state == st_ts2_id);
								state     <= st_head;
							end
						end else begin
							state <= st_head;
						end
					end

					default: begin
						state <= st_head;
					end
				endcase
			end
		end
	end

endmodule

// ==== verilog/rx_lane_align.sv ====
`timescale 1ns/1ps

module rx_lane_align (
	input  logic                                 clk,
	input  logic                                 rst_n,
	input  logic [pcie_ts_pkg::num_lanes*16-1:0] rx_data,
	input  logic [pcie_ts_pkg::num_lanes*2-1:0]  rx_charisk,
	input  logic [pcie_ts_pkg::num_lanes*2-1:0]  rx_err,
	output logic [pcie_ts_pkg::num_lanes*16-1:0] al_data,
	output logic [pcie_ts_pkg::num_lanes*2-1:0]  al_charisk,
	output logic [pcie_ts_pkg::num_lanes*2-1:0]  al_err
);

	// Previous symbol pair per lane
	logic [pcie_ts_pkg::num_lanes*16-1:0] prev_data;
	logic [pcie_ts_pkg::num_lanes*2-1:0]  prev_charisk;
	logic [pcie_ts_pkg::num_lanes*2-1:0]  prev_err;

	// Byte offset per lane, 1 when the comma arrived in the high byte
	logic [pcie_ts_pkg::num_lanes-1:0] offset;

	// Comma position in the current pair
	logic [pcie_ts_pkg::num_lanes-1:0] com_lo;
	logic [pcie_ts_pkg::num_lanes-1:0] com_hi;

	always_comb begin
		for (int i = 0; i < pcie_ts_pkg::num_lanes; i++) begin
			com_lo[i] = rx_charisk[2*i] && (rx_data[16*i +: 8] == pcie_ts_pkg::sym_com);
			com_hi[i] = rx_charisk[2*i+1] && (rx_data[16*i+8 +: 8] == pcie_ts_pkg::sym_com);
		end
	end

	// Offset follows the latest comma, low byte wins if both are commas
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			offset <= '0;
		end else begin
			for (int i = 0; i < pcie_ts_pkg::num_lanes; i++) begin
				if (com_lo[i])
					offset[i] <= 1'b0;
				else if (com_hi[i])
					offset[i] <= 1'b1;
			end
		end
	end

	// Data path, one cycle of history plus the output register
	always_ff @(posedge clk) begin
		prev_data <= rx_data;
		for (int i = 0; i < pcie_ts_pkg::num_lanes; i++) begin
			// Offset 1 pairs the old high byte with the new low byte
			if (offset[i])
				al_data[16*i +: 16] <= {rx_data[16*i +: 8], prev_data[16*i+8 +: 8]};
			else
				al_data[16*i +: 16] <= prev_data[16*i +: 16];
		end
	end

	// K-flags and decode errors move with their symbols
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			prev_charisk <= '0;
			prev_err     <= '0;
			al_charisk   <= '0;
			al_err       <= '0;
		end else begin
			prev_charisk <= rx_charisk;
			prev_err     <= rx_err;
			for (int i = 0; i < pcie_ts_pkg::num_lanes; i++) begin
				if (offset[i]) begin
					al_charisk[2*i +: 2] <= {rx_charisk[2*i], prev_charisk[2*i+1]};
					al_err[2*i +: 2]     <= {rx_err[2*i], prev_err[2*i+1]};
				end else begin
					al_charisk[2*i +: 2] <= prev_charisk[2*i +: 2];
					al_err[2*i +: 2]     <= prev_err[2*i +: 2];
				end
			end
		end
	end

endmodule

// ==== common/pcie_ts_pkg.sv ====
package pcie_ts_pkg;

	// Link width in lanes
	localparam int num_lanes = 4;

	// K28.5 comma, starts every ordered set
	localparam logic [7:0] sym_com = 8'hbc;

	// K23.7 PAD, stands in for an unassigned link or lane number
	localparam logic [7:0] sym_pad = 8'hf7;

	// TS1 identifier, D10.2
	localparam logic [7:0] ts1_id = 8'h4a;

	// TS2 identifier, D5.2
	localparam logic [7:0] ts2_id = 8'h45;

	// Largest legal link or lane number
	localparam int max_link_lane = 31;

	// One training set is 16 symbols, so 8 symbol pairs
	localparam int ts_words = 8;

	// Identifier pairs that follow the first identifier pair
	localparam int ts_id_words = 4;

	// Consecutive identical sets needed before a lane counts as locked
	localparam int ts_lock_count = 8;

	// Width of the lock run counter, must hold ts_lock_count
	localparam int lock_cnt_w = $clog2(ts_lock_count + 1);

	// N_FTS field width
	localparam int fts_w = 8;

	// Link and lane number field width
	localparam int link_w = 5;

endpackage
